// ==== source/periph_pkg.sv ====
// Supports word-aligned 32-bit APB accesses only; each slave owns a 256-byte region
`default_nettype none

package periph_pkg;

   // Bus widths
   localparam int unsigned APB_ADDR_W = 32;
   localparam int unsigned APB_DATA_W = 32;

   // Address field that picks the slave
   localparam int unsigned REGION_LSB = 8;
   localparam int unsigned REGION_W   = 4;

   localparam logic [REGION_W-1:0] REGION_GPIO     = 4'd0;
   localparam logic [REGION_W-1:0] REGION_SOC_CTRL = 4'd1;

   // Read value of an unmapped region
   localparam logic [APB_DATA_W-1:0] ERR_RDATA = 32'hdeadcaca;

   // GPIO register offsets
   localparam logic [REGION_LSB-1:0] GPIO_DIR_OFFS = 8'h00;
   localparam logic [REGION_LSB-1:0] GPIO_OUT_OFFS = 8'h04;
   localparam logic [REGION_LSB-1:0] GPIO_IN_OFFS  = 8'h08;

   // SoC control register offsets
   localparam logic [REGION_LSB-1:0] CLUSTER_CTRL_OFFS = 8'h00;
   localparam logic [REGION_LSB-1:0] GWT_CFG_OFFS      = 8'h04;

   // Cluster control bits
   localparam int unsigned CTRL_RST_BIT     = 0;
   localparam int unsigned CTRL_FETCH_BIT   = 1;
   localparam int unsigned CTRL_SA_BOOT_BIT = 2;

   // Cluster held in reset, fetch and standalone boot off
   localparam logic [APB_DATA_W-1:0] CLUSTER_CTRL_RESET = 32'h1 << CTRL_RST_BIT;

   typedef enum logic [1:0] {
      GPIO,
      SOC_CTRL,
      NONE
   } slave_sel_e;

endpackage

`default_nettype wire

// ==== source/apb_if.sv ====
// APB3 signal bundle with fixed widths from periph_pkg; carries no clock, no pprot or pstrb
`timescale 1ns/1ps
`default_nettype none

interface apb_if;

   logic [periph_pkg::APB_ADDR_W-1:0] paddr;
   logic                              pwrite;
   logic                              psel;
   logic                              penable;
   logic [periph_pkg::APB_DATA_W-1:0] pwdata;
   logic [periph_pkg::APB_DATA_W-1:0] prdata;
   logic                              pready;
   logic                              pslverr;

   // Request side
   modport master (
      output paddr, pwrite, psel, penable, pwdata,
      input  prdata, pready, pslverr
   );

   // Response side
   modport slave (
      input  paddr, pwrite, psel, penable, pwdata,
      output prdata, pready, pslverr
   );

endinterface

`default_nettype wire

// ==== source/apb_periph_decode.sv ====
// Purely combinational; regions other than GPIO and SoC control answer with an error at once
`timescale 1ns/1ps
`default_nettype none

module apb_periph_decode (
   apb_if.slave  up_bus,
   apb_if.master gpio_bus,
   apb_if.master ctrl_bus
);

   logic [periph_pkg::REGION_W-1:0] region;
   periph_pkg::slave_sel_e          sel;
   logic                            access;

   assign region = up_bus.paddr[periph_pkg::REGION_LSB +: periph_pkg::REGION_W];
   assign access = up_bus.psel & up_bus.penable;

   always_comb begin
      case (region)
         periph_pkg::REGION_GPIO:     sel = periph_pkg::GPIO;
         periph_pkg::REGION_SOC_CTRL: sel = periph_pkg::SOC_CTRL;
         default:                     sel = periph_pkg::NONE;
      endcase
   end

   // Shared request lines, psel only toward the addressed block
   assign gpio_bus.paddr   = up_bus.paddr;
   assign gpio_bus.pwrite  = up_bus.pwrite;
   assign gpio_bus.penable = up_bus.penable;
   assign gpio_bus.pwdata  = up_bus.pwdata;
   assign gpio_bus.psel    = up_bus.psel & (sel == periph_pkg::GPIO);

   assign ctrl_bus.paddr   = up_bus.paddr;
   assign ctrl_bus.pwrite  = up_bus.pwrite;
   assign ctrl_bus.penable = up_bus.penable;
   assign ctrl_bus.pwdata  = up_bus.pwdata;
   assign ctrl_bus.psel    = up_bus.psel & (sel == periph_pkg::SOC_CTRL);

   // Response mux
   always_comb begin
      case (sel)
         periph_pkg::GPIO: begin
            up_bus.prdata  = gpio_bus.prdata;
            up_bus.pready  = gpio_bus.pready;
            up_bus.pslverr = gpio_bus.pslverr;
         end
         periph_pkg::SOC_CTRL: begin
            up_bus.prdata  = ctrl_bus.prdata;
            up_bus.pready  = ctrl_bus.pready;
            up_bus.pslverr = ctrl_bus.pslverr;
         end
         default: begin
            // Unmapped, no slave sees the transfer
            up_bus.prdata  = periph_pkg::ERR_RDATA;
            up_bus.pready  = access;
            up_bus.pslverr = access;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== source/apb_gpio.sv ====
// NUM_GPIO must be 1 to 32; zero-wait slave, pins above NUM_GPIO read as zero, no interrupts
`timescale 1ns/1ps
`default_nettype none

module apb_gpio #(
   parameter int unsigned NUM_GPIO = 32
) (
   input  logic                clk_i,
   input  logic                rst_i,
   apb_if.slave                bus,
   input  logic [NUM_GPIO-1:0] gpio_in_i,
   output logic [NUM_GPIO-1:0] gpio_out_o,
   output logic [NUM_GPIO-1:0] gpio_dir_o
);

   logic [periph_pkg::REGION_LSB-1:0] offs;
   logic                              wr_en;
   logic [NUM_GPIO-1:0]               dir_q;
   logic [NUM_GPIO-1:0]               out_q;
   logic [NUM_GPIO-1:0]               sync1_q;
   logic [NUM_GPIO-1:0]               sync2_q;
   logic [periph_pkg::APB_DATA_W-1:0] rdata;

   assign offs  = bus.paddr[periph_pkg::REGION_LSB-1:0];
   assign wr_en = bus.psel & bus.penable & bus.pwrite;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         dir_q <= '0;
         out_q <= '0;
      end else if (wr_en) begin
         case (offs)
            periph_pkg::GPIO_DIR_OFFS: dir_q <= bus.pwdata[NUM_GPIO-1:0];
            periph_pkg::GPIO_OUT_OFFS: out_q <= bus.pwdata[NUM_GPIO-1:0];
            // GPIO_IN is read only
            default: ;
         endcase
      end
   end

   // Two-flop synchronizer for asynchronous pins
   always_ff @(posedge clk_i) begin
      sync1_q <= gpio_in_i;
      sync2_q <= sync1_q;
   end

   always_comb begin
      rdata = '0;
      case (offs)
         periph_pkg::GPIO_DIR_OFFS: rdata[NUM_GPIO-1:0] = dir_q;
         periph_pkg::GPIO_OUT_OFFS: rdata[NUM_GPIO-1:0] = out_q;
         periph_pkg::GPIO_IN_OFFS:  rdata[NUM_GPIO-1:0] = sync2_q;
         default:                   rdata = '0;
      endcase
   end

   assign bus.prdata  = rdata;
   assign bus.pready  = bus.psel & bus.penable;
   assign bus.pslverr = 1'b0;

   assign gpio_dir_o = dir_q;
   assign gpio_out_o = out_q;

endmodule

`default_nettype wire

// ==== source/apb_soc_ctrl.sv ====
// Zero-wait slave; the external configuration load wins over a same-cycle APB write
`timescale 1ns/1ps
`default_nettype none

module apb_soc_ctrl (
   input  logic                              clk_i,
   input  logic                              rst_i,
   apb_if.slave                              bus,
   input  logic [periph_pkg::APB_DATA_W-1:0] gwt_cfg_i,
   input  logic                              gwt_cfg_ie_i,
   output logic [periph_pkg::APB_DATA_W-1:0] gwt_cfg_o,
   output logic                              cluster_rst_o,
   output logic                              cluster_fetch_en_o,
   output logic                              cluster_sa_boot_o
);

   // Writable width of cluster control
   localparam int unsigned CTRL_W = periph_pkg::CTRL_SA_BOOT_BIT + 1;

   logic [periph_pkg::REGION_LSB-1:0] offs;
   logic                              wr_en;
   logic                              ctrl_wr;
   logic                              gwt_wr;
   logic [CTRL_W-1:0]                 ctrl_q;
   logic [periph_pkg::APB_DATA_W-1:0] gwt_q;
   logic [periph_pkg::APB_DATA_W-1:0] rdata;

   assign offs    = bus.paddr[periph_pkg::REGION_LSB-1:0];
   assign wr_en   = bus.psel & bus.penable & bus.pwrite;
   assign ctrl_wr = wr_en & (offs == periph_pkg::CLUSTER_CTRL_OFFS);
   assign gwt_wr  = wr_en & (offs == periph_pkg::GWT_CFG_OFFS);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ctrl_q <= periph_pkg::CLUSTER_CTRL_RESET[CTRL_W-1:0];
      end else if (ctrl_wr) begin
         ctrl_q <= bus.pwdata[CTRL_W-1:0];
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         gwt_q <= '0;
      end else if (gwt_cfg_ie_i) begin
         gwt_q <= gwt_cfg_i;
      end else if (gwt_wr) begin
         gwt_q <= bus.pwdata;
      end
   end

   always_comb begin
      rdata = '0;
      case (offs)
         periph_pkg::CLUSTER_CTRL_OFFS: rdata[CTRL_W-1:0] = ctrl_q;
         periph_pkg::GWT_CFG_OFFS:      rdata = gwt_q;
         default:                       rdata = '0;
      endcase
   end

   assign bus.prdata  = rdata;
   assign bus.pready  = bus.psel & bus.penable;
   assign bus.pslverr = 1'b0;

   // Cluster stays in reset while the subsystem itself is reset
   assign cluster_rst_o      = rst_i | ctrl_q[periph_pkg::CTRL_RST_BIT];
   assign cluster_fetch_en_o = ctrl_q[periph_pkg::CTRL_FETCH_BIT];
   assign cluster_sa_boot_o  = ctrl_q[periph_pkg::CTRL_SA_BOOT_BIT];
   assign gwt_cfg_o          = gwt_q;

endmodule

`default_nettype wire

// ==== source/apb_periph_subsystem.sv ====
// Single clock domain; every APB transfer is setup plus one access cycle, never stalled
`timescale 1ns/1ps
`default_nettype none

module apb_periph_subsystem #(
   parameter int unsigned NUM_GPIO = 32
) (
   input  logic                              clk_i,
   input  logic                              rst_i,
   input  logic [periph_pkg::APB_ADDR_W-1:0] paddr_i,
   input  logic                              pwrite_i,
   input  logic                              psel_i,
   input  logic                              penable_i,
   input  logic [periph_pkg::APB_DATA_W-1:0] pwdata_i,
   output logic [periph_pkg::APB_DATA_W-1:0] prdata_o,
   output logic                              pready_o,
   output logic                              pslverr_o,
   input  logic [NUM_GPIO-1:0]               gpio_in_i,
   output logic [NUM_GPIO-1:0]               gpio_out_o,
   output logic [NUM_GPIO-1:0]               gpio_dir_o,
   output logic                              cluster_rst_o,
   output logic                              cluster_fetch_en_o,
   output logic                              cluster_sa_boot_o,
   input  logic [periph_pkg::APB_DATA_W-1:0] gwt_cfg_i,
   input  logic                              gwt_cfg_ie_i,
   output logic [periph_pkg::APB_DATA_W-1:0] gwt_cfg_o
);

   apb_if up_bus ();
   apb_if gpio_bus ();
   apb_if ctrl_bus ();

   // Pins to upstream bus
   assign up_bus.paddr   = paddr_i;
   assign up_bus.pwrite  = pwrite_i;
   assign up_bus.psel    = psel_i;
   assign up_bus.penable = penable_i;
   assign up_bus.pwdata  = pwdata_i;

   assign prdata_o  = up_bus.prdata;
   assign pready_o  = up_bus.pready;
   assign pslverr_o = up_bus.pslverr;

   apb_periph_decode i_decode (
      .up_bus   ( up_bus   ),
      .gpio_bus ( gpio_bus ),
      .ctrl_bus ( ctrl_bus )
   );

   apb_gpio #(
      .NUM_GPIO ( NUM_GPIO )
   ) i_apb_gpio (
      .clk_i      ( clk_i      ),
      .rst_i      ( rst_i      ),
      .bus        ( gpio_bus   ),
      .gpio_in_i  ( gpio_in_i  ),
      .gpio_out_o ( gpio_out_o ),
      .gpio_dir_o ( gpio_dir_o )
   );

   apb_soc_ctrl i_soc_ctrl (
      .clk_i              ( clk_i              ),
      .rst_i              ( rst_i              ),
      .bus                ( ctrl_bus           ),
      .gwt_cfg_i          ( gwt_cfg_i          ),
      .gwt_cfg_ie_i       ( gwt_cfg_ie_i       ),
      .gwt_cfg_o          ( gwt_cfg_o          ),
      .cluster_rst_o      ( cluster_rst_o      ),
      .cluster_fetch_en_o ( cluster_fetch_en_o ),
      .cluster_sa_boot_o  ( cluster_sa_boot_o  )
   );

endmodule

`default_nettype wire

// ==== tests/apb_periph_subsystem_sva.sv ====
// Expects zero-wait transfers of exactly setup plus access; checks the top-level port only
`timescale 1ns/1ps
`default_nettype none

module apb_periph_subsystem_sva #(
   parameter int unsigned NUM_GPIO = 32
) (
   input logic                              clk_i,
   input logic                              rst_i,
   input logic [periph_pkg::APB_ADDR_W-1:0] paddr_i,
   input logic                              pwrite_i,
   input logic                              psel_i,
   input logic                              penable_i,
   input logic [periph_pkg::APB_DATA_W-1:0] pwdata_i,
   input logic [periph_pkg::APB_DATA_W-1:0] prdata_o,
   input logic                              pready_o,
   input logic                              pslverr_o,
   input logic [NUM_GPIO-1:0]               gpio_out_o,
   input logic [NUM_GPIO-1:0]               gpio_dir_o,
   input logic                              cluster_rst_o,
   input logic                              cluster_fetch_en_o,
   input logic                              cluster_sa_boot_o,
   input logic [periph_pkg::APB_DATA_W-1:0] gwt_cfg_o
);

   periph_pkg::slave_sel_e sel;
   logic                   access;

   assign access = psel_i & penable_i;

   always_comb begin
      case (paddr_i[periph_pkg::REGION_LSB +: periph_pkg::REGION_W])
         periph_pkg::REGION_GPIO:     sel = periph_pkg::GPIO;
         periph_pkg::REGION_SOC_CTRL: sel = periph_pkg::SOC_CTRL;
         default:                     sel = periph_pkg::NONE;
      endcase
   end

   a_ready_in_access: assert property (@(posedge clk_i) disable iff (rst_i)
      access |-> pready_o)
      else $error("pready_o low in an access cycle");

   a_no_err_outside: assert property (@(posedge clk_i) disable iff (rst_i)
      !access |-> !pslverr_o)
      else $error("pslverr_o high outside an access cycle");

   a_setup_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      (psel_i && !penable_i) |=>
         (psel_i && penable_i && $stable(paddr_i) && $stable(pwrite_i) && $stable(pwdata_i)))
      else $error("request changed between setup and access");

   a_access_after_setup: assert property (@(posedge clk_i) disable iff (rst_i)
      access |-> $past(psel_i && !penable_i))
      else $error("access cycle without a setup cycle");

   a_unmapped_err: assert property (@(posedge clk_i) disable iff (rst_i)
      (access && sel == periph_pkg::NONE) |-> (pslverr_o && prdata_o == periph_pkg::ERR_RDATA))
      else $error("unmapped access without error response");

   // Registers are reset one edge after rst_i is seen
   a_reset_state: assert property (@(posedge clk_i)
      rst_i |=> (gpio_dir_o == '0 && gpio_out_o == '0 && cluster_rst_o &&
                 !cluster_fetch_en_o && !cluster_sa_boot_o && gwt_cfg_o == '0))
      else $error("outputs left the reset state during reset");

endmodule

bind apb_periph_subsystem apb_periph_subsystem_sva #(.NUM_GPIO(NUM_GPIO)) sva0 (.*);

`default_nettype wire

// ==== tests/tb_apb_periph_subsystem.sv ====
// Runs the DUT at NUM_GPIO = 32; relies on two-cycle zero-wait APB transfers
`timescale 1ns/1ps
`default_nettype none

module tb_apb_periph_subsystem;

   localparam int          CLK_PERIOD  = 20;
   localparam int          RST_CYCLES  = 16;
   localparam int          NUM_TESTS   = 6;
   localparam int          TEST_CYCLES = 150;
   localparam logic [31:0] LFSR_SEED   = 32'd83;
   localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

   logic        clk_i;
   logic        rst_i;
   logic [31:0] paddr_i;
   logic        pwrite_i;
   logic        psel_i;
   logic        penable_i;
   logic [31:0] pwdata_i;
   logic [31:0] prdata_o;
   logic        pready_o;
   logic        pslverr_o;
   logic [31:0] gpio_in_i;
   logic [31:0] gpio_out_o;
   logic [31:0] gpio_dir_o;
   logic        cluster_rst_o;
   logic        cluster_fetch_en_o;
   logic        cluster_sa_boot_o;
   logic [31:0] gwt_cfg_i;
   logic        gwt_cfg_ie_i;
   logic [31:0] gwt_cfg_o;

   // Shadow model of the registers
   logic [31:0] exp_dir;
   logic [31:0] exp_out;
   logic [2:0]  exp_ctrl;
   logic [31:0] exp_gwt;
   logic [31:0] lfsr;
   logic        ext_load;
   int          errors;
   int          pass_cnt;
   int          fail_cnt;

   apb_periph_subsystem #(
      .NUM_GPIO ( 32 )
   ) dut0 (
      .clk_i, .rst_i, .paddr_i, .pwrite_i, .psel_i, .penable_i, .pwdata_i,
      .prdata_o, .pready_o, .pslverr_o, .gpio_in_i, .gpio_out_o, .gpio_dir_o,
      .cluster_rst_o, .cluster_fetch_en_o, .cluster_sa_boot_o,
      .gwt_cfg_i, .gwt_cfg_ie_i, .gwt_cfg_o
   );

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   initial begin
      #(CLK_PERIOD * (RST_CYCLES + NUM_TESTS * TEST_CYCLES + 50));
      $display("Run timed out before all tests finished");
      $display("Testbench failed");
      $finish;
   end

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
         val  = {val[30:0], lfsr[0]};
      end
      return val;
   endfunction

   function automatic logic [31:0] reg_addr(input logic [3:0] region, input logic [7:0] offs);
      return {20'h0, region, offs};
   endfunction

   task automatic check(input string name, input logic [31:0] exp_val, input logic [31:0] act_val);
      assert (act_val === exp_val) else begin
         $display("Fail %s expected %08h actual %08h", name, exp_val, act_val);
         errors++;
      end
   endtask

   // Setup and access cycle; ext_load raises gwt_cfg_ie_i at the edge ending the access
   task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
      @(posedge clk_i);
      #2;
      paddr_i   = addr;
      pwrite_i  = wr;
      pwdata_i  = wdata;
      psel_i    = 1'b1;
      penable_i = 1'b0;
      @(posedge clk_i);
      #2;
      penable_i    = 1'b1;
      gwt_cfg_ie_i = ext_load;
      #(CLK_PERIOD / 2);
      assert (pready_o === 1'b1) else begin
         $display("No pready in the access cycle at address %08h", addr);
         errors++;
      end
      rdata = prdata_o;
      err   = pslverr_o;
      @(posedge clk_i);
      #2;
      psel_i       = 1'b0;
      penable_i    = 1'b0;
      gwt_cfg_ie_i = 1'b0;
   endtask

   task automatic write_reg(input string name, input logic [31:0] addr, input logic [31:0] data);
      logic [31:0] rd;
      logic        err;
      apb_xfer(1'b1, addr, data, rd, err);
      check({name, " write pslverr"}, 32'd0, {31'b0, err});
   endtask

   task automatic read_check(input string name, input logic [31:0] addr, input logic [31:0] exp_val);
      logic [31:0] rd;
      logic        err;
      apb_xfer(1'b0, addr, 32'd0, rd, err);
      check({name, " read"}, exp_val, rd);
      check({name, " read pslverr"}, 32'd0, {31'b0, err});
   endtask

   task automatic check_outputs(input string name);
      check({name, " gpio_dir"}, exp_dir, gpio_dir_o);
      check({name, " gpio_out"}, exp_out, gpio_out_o);
      check({name, " cluster"}, {29'b0, exp_ctrl[2], exp_ctrl[1], rst_i | exp_ctrl[0]},
            {29'b0, cluster_sa_boot_o, cluster_fetch_en_o, cluster_rst_o});
      check({name, " gwt_cfg"}, exp_gwt, gwt_cfg_o);
   endtask

   task automatic read_all(input string name);
      read_check({name, " dir"}, reg_addr(periph_pkg::REGION_GPIO, 8'h00), exp_dir);
      read_check({name, " out"}, reg_addr(periph_pkg::REGION_GPIO, 8'h04), exp_out);
      read_check({name, " ctrl"}, reg_addr(periph_pkg::REGION_SOC_CTRL, 8'h00), {29'b0, exp_ctrl});
      read_check({name, " gwt"}, reg_addr(periph_pkg::REGION_SOC_CTRL, 8'h04), exp_gwt);
   endtask

   task automatic finish_test(input string name, input int start);
      if (errors == start) begin
         pass_cnt++;
         $display("%s: ok", name);
      end else begin
         fail_cnt++;
         $display("%s: %0d errors", name, errors - start);
      end
   endtask

   initial begin
      logic [31:0] d;
      logic [31:0] rd;
      logic        err;
      int          start;
      rst_i        = 1'b1;
      paddr_i      = '0;
      pwrite_i     = 1'b0;
      psel_i       = 1'b0;
      penable_i    = 1'b0;
      pwdata_i     = '0;
      gpio_in_i    = '0;
      gwt_cfg_i    = '0;
      gwt_cfg_ie_i = 1'b0;
      ext_load     = 1'b0;
      lfsr         = LFSR_SEED;
      errors       = 0;
      pass_cnt     = 0;
      fail_cnt     = 0;
      exp_dir      = '0;
      exp_out      = '0;
      exp_ctrl     = 3'b001;
      exp_gwt      = '0;

      start = errors;
      repeat (RST_CYCLES) @(posedge clk_i);
      #2;
      check_outputs("in reset");
      rst_i = 1'b0;
      @(posedge clk_i);
      #2;
      check_outputs("after reset");
      check("idle pready", 32'd0, {31'b0, pready_o});
      check("idle pslverr", 32'd0, {31'b0, pslverr_o});
      read_all("reset");
      finish_test("reset values", start);

      start = errors;
      repeat (4) begin
         exp_dir = rand_bits(32);
         write_reg("gpio dir", reg_addr(periph_pkg::REGION_GPIO, 8'h00), exp_dir);
         exp_out = rand_bits(32);
         write_reg("gpio out", reg_addr(periph_pkg::REGION_GPIO, 8'h04), exp_out);
         check_outputs("gpio write");
         read_all("gpio");
      end
      // GPIO_IN is read only
      write_reg("gpio in", reg_addr(periph_pkg::REGION_GPIO, 8'h08), rand_bits(32));
      check_outputs("gpio in write");
      read_all("gpio in write");
      finish_test("gpio write", start);

      start = errors;
      repeat (4) begin
         d         = rand_bits(32);
         gpio_in_i = d;
         repeat (3) @(posedge clk_i);
         #2;
         read_check("gpio in", reg_addr(periph_pkg::REGION_GPIO, 8'h08), d);
      end
      finish_test("gpio input", start);

      start = errors;
      for (int c = 0; c < 8; c++) begin
         exp_ctrl = 3'(c);
         d        = rand_bits(29);
         write_reg("cluster ctrl", reg_addr(periph_pkg::REGION_SOC_CTRL, 8'h00), {d[28:0], exp_ctrl});
         check_outputs("cluster ctrl");
         read_all("cluster ctrl");
      end
      finish_test("cluster control", start);

      start = errors;
      exp_gwt = rand_bits(32);
      write_reg("gwt", reg_addr(periph_pkg::REGION_SOC_CTRL, 8'h04), exp_gwt);
      check_outputs("gwt write");
      read_all("gwt write");
      // External load at the same edge as the APB write
      gwt_cfg_i = rand_bits(32);
      ext_load  = 1'b1;
      write_reg("gwt ext", reg_addr(periph_pkg::REGION_SOC_CTRL, 8'h04), rand_bits(32));
      ext_load  = 1'b0;
      exp_gwt   = gwt_cfg_i;
      check_outputs("gwt ext");
      read_all("gwt ext");
      finish_test("global config", start);

      start = errors;
      for (int k = 0; k < 2; k++) begin
         apb_xfer(1'b1, reg_addr(4'd5, 8'(k * 4)), rand_bits(32), rd, err);
         check("unmapped write pslverr", 32'd1, {31'b0, err});
         apb_xfer(1'b0, reg_addr(4'd5, 8'(k * 4)), 32'd0, rd, err);
         check("unmapped read data", 32'hdeadcaca, rd);
         check("unmapped read pslverr", 32'd1, {31'b0, err});
      end
      check_outputs("unmapped");
      read_all("unmapped");
      read_check("gpio unknown offset", reg_addr(periph_pkg::REGION_GPIO, 8'h0c), 32'd0);
      read_check("soc unknown offset", reg_addr(periph_pkg::REGION_SOC_CTRL, 8'h08), 32'd0);
      finish_test("unmapped region", start);

      $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
source/periph_pkg.sv
source/apb_if.sv
source/apb_periph_decode.sv
source/apb_gpio.sv
source/apb_soc_ctrl.sv
source/apb_periph_subsystem.sv
tests/apb_periph_subsystem_sva.sv
tests/tb_apb_periph_subsystem.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_apb_periph_subsystem \
   -f build.f -o tb_sim

out=$(./obj_dir/tb_sim 2>&1 || true)
printf '%s\n' "$out"

# Fails the script when the pass line is missing
printf '%s\n' "$out" | grep -qx 'Testbench passed'
